// ==== sim.f ====
hw/core_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core_top.sv
dv/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator, then check the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module core_tb -o core_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== dv/core_tb.sv ====
// testbench for core_top, builds a program with its expected trace and checks writes and stores
`timescale 1ns/1ps

module core_tb;

    localparam core_pkg::word_t RESET_PC = 32'hbfc0_0000;
    localparam int              N_TESTS  = 5;
    localparam int unsigned     SEED     = 32'h6d29_d988;

    // one expected register write or store
    typedef struct packed {
        logic [7:0]      test;
        core_pkg::word_t pc;
        core_pkg::word_t key;
        core_pkg::word_t value;
    } entry_t;

    logic                clk_i;
    logic                rst_i;
    logic                ibus_en_o;
    core_pkg::word_t     ibus_addr_o;
    core_pkg::word_t     ibus_rdata_i;
    logic                dbus_en_o;
    logic [3:0]          dbus_wen_o;
    core_pkg::word_t     dbus_addr_o;
    core_pkg::word_t     dbus_wdata_o;
    core_pkg::word_t     dbus_rdata_i;
    core_pkg::word_t     debug_wb_pc_o;
    logic [3:0]          debug_wb_wen_o;
    core_pkg::reg_addr_t debug_wb_wraddr_o;
    core_pkg::word_t     debug_wb_wrdata_o;

    core_pkg::word_t imem [256];
    logic [7:0]      inst_test [256];
    core_pkg::word_t dmem [256];
    core_pkg::word_t ref_mem [core_pkg::word_t];
    core_pkg::word_t imem_off;
    entry_t          wb_q [$];
    entry_t          st_q [$];
    entry_t          wb_exp, st_exp;
    logic            wb_have, st_have, reset_reported;
    string           test_name [N_TESTS];
    int              n_inst [N_TESTS];
    int              remaining [N_TESTS];
    int              test_err [N_TESTS];
    int              prog_len, tests_done, n_checks, n_errors, run_cycles, limit;
    int unsigned     cyc;

    core_top #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .ibus_en_o         (ibus_en_o),
        .ibus_addr_o       (ibus_addr_o),
        .ibus_rdata_i      (ibus_rdata_i),
        .dbus_en_o         (dbus_en_o),
        .dbus_wen_o        (dbus_wen_o),
        .dbus_addr_o       (dbus_addr_o),
        .dbus_wdata_o      (dbus_wdata_o),
        .dbus_rdata_i      (dbus_rdata_i),
        .debug_wb_pc_o     (debug_wb_pc_o),
        .debug_wb_wen_o    (debug_wb_wen_o),
        .debug_wb_wraddr_o (debug_wb_wraddr_o),
        .debug_wb_wrdata_o (debug_wb_wrdata_o)
    );

    // both memories answer in the same cycle, past the program end the core sees nops
    assign imem_off     = ibus_addr_o - RESET_PC;
    assign ibus_rdata_i = (imem_off < 32'd1024) ? imem[imem_off[9:2]] : 32'h0;
    // data only comes back while the bus is enabled
    assign dbus_rdata_i = dbus_en_o ? dmem[dbus_addr_o[9:2]] : 32'h0;

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            cyc <= 0;
        end else if (cyc < 1000) begin
            cyc <= cyc + 1;
        end
    end

    function automatic core_pkg::word_t fill_word(core_pkg::word_t addr);
        return (addr * 32'h0001_0003) ^ 32'ha5a5_a5a5;
    endfunction

    function automatic core_pkg::word_t r_inst(logic [5:0] fn, logic [4:0] rd, logic [4:0] rs,
                                               logic [4:0] rt, logic [4:0] sh);
        return {core_pkg::OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic core_pkg::word_t i_inst(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                               logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] rnd16();
        return 16'($urandom);
    endfunction

    function automatic logic [15:0] word_off();
        return 16'(($urandom % 32) * 4);
    endfunction

    task automatic put(logic [7:0] t, core_pkg::word_t w);
        imem[prog_len]      = w;
        inst_test[prog_len] = t;
        n_inst[t]++;
        prog_len++;
    endtask

    task automatic add_expected(logic is_store, logic [7:0] t, core_pkg::word_t inst_pc,
                                core_pkg::word_t key, core_pkg::word_t value);
        entry_t e;
        e = '{test: t, pc: inst_pc, key: key, value: value};
        if (is_store) begin
            st_q.push_back(e);
        end else begin
            wb_q.push_back(e);
        end
        remaining[t]++;
    endtask

    task automatic build_program();
        logic [15:0] off1, off2, off3, off4;
        off1 = word_off();
        off2 = word_off();
        off3 = word_off();
        off4 = word_off();
        // dependent chain, each result feeds the next from execute or memory
        put(1, i_inst(core_pkg::OP_ADDIU, 1, 0, rnd16()));
        put(1, i_inst(core_pkg::OP_ADDIU, 2, 1, rnd16()));
        put(1, r_inst(core_pkg::FN_ADDU, 3, 1, 2, 0));
        put(1, r_inst(core_pkg::FN_SUBU, 4, 3, 1, 0));
        put(1, r_inst(core_pkg::FN_AND, 5, 4, 3, 0));
        put(1, r_inst(core_pkg::FN_OR, 6, 5, 2, 0));
        put(1, r_inst(core_pkg::FN_XOR, 7, 6, 4, 0));
        put(1, r_inst(core_pkg::FN_SLT, 8, 7, 3, 0));
        put(1, r_inst(core_pkg::FN_SLL, 9, 0, 7, 5'($urandom % 32)));
        put(1, i_inst(core_pkg::OP_ORI, 11, 9, rnd16()));
        put(1, i_inst(core_pkg::OP_LUI, 12, 0, rnd16()));
        // r12 sits in execute and memory at once for the next addu
        put(1, i_inst(core_pkg::OP_ADDIU, 12, 12, rnd16()));
        put(1, r_inst(core_pkg::FN_ADDU, 13, 12, 11, 0));
        put(1, r_inst(core_pkg::FN_SLT, 14, 3, 7, 0));
        // loads used at once, on rs and then on rt
        put(2, i_inst(core_pkg::OP_ADDIU, 10, 0, 16'h0100));
        put(2, i_inst(core_pkg::OP_ORI, 15, 0, rnd16()));
        put(2, i_inst(core_pkg::OP_SW, 15, 10, off1));
        put(2, i_inst(core_pkg::OP_LW, 16, 10, off1));
        put(2, r_inst(core_pkg::FN_ADDU, 17, 16, 13, 0));
        put(2, i_inst(core_pkg::OP_LW, 18, 10, 16'h0 - off2));
        put(2, r_inst(core_pkg::FN_SUBU, 19, 16, 18, 0));
        // taken beq skips r23, not-taken bne reaches r25
        put(3, i_inst(core_pkg::OP_ADDIU, 20, 0, 16'd5));
        put(3, i_inst(core_pkg::OP_ADDIU, 21, 0, 16'd5));
        put(3, i_inst(core_pkg::OP_BEQ, 21, 20, 16'd2));
        put(3, i_inst(core_pkg::OP_ADDIU, 22, 0, 16'd1));
        put(3, i_inst(core_pkg::OP_ADDIU, 23, 0, 16'd99));
        put(3, i_inst(core_pkg::OP_BNE, 21, 20, 16'd2));
        put(3, i_inst(core_pkg::OP_ADDIU, 24, 22, 16'd10));
        put(3, i_inst(core_pkg::OP_ADDIU, 25, 24, 16'd1));
        // stores with forwarded data, r0 as a target and as a source
        put(4, i_inst(core_pkg::OP_ADDIU, 26, 0, rnd16()));
        put(4, i_inst(core_pkg::OP_SW, 26, 10, off3));
        put(4, i_inst(core_pkg::OP_ADDIU, 0, 26, 16'd3));
        put(4, i_inst(core_pkg::OP_SW, 0, 10, off4));
        put(4, r_inst(core_pkg::FN_ADDU, 27, 0, 26, 0));
        put(4, i_inst(core_pkg::OP_SW, 27, 10, 16'h0 - off4));
        put(4, i_inst(core_pkg::OP_LW, 28, 10, off3));
    endtask

    // sequential ISA model with one delay slot per branch
    task automatic model_program();
        core_pkg::word_t regs [32];
        core_pkg::word_t pc, npc, nxt, w, a, b, se, res, addr;
        logic [4:0]      wd;
        logic            wr;
        int              idx;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc  = RESET_PC;
        npc = RESET_PC + 32'd4;
        while (pc - RESET_PC < 32'(4 * prog_len)) begin
            idx = int'((pc - RESET_PC) >> 2);
            w   = imem[idx];
            a   = regs[w[25:21]];
            b   = regs[w[20:16]];
            se  = {{16{w[15]}}, w[15:0]};
            res = '0;
            wr  = 1'b1;
            wd  = w[20:16];
            nxt = npc + 32'd4;
            case (w[31:26])
                core_pkg::OP_SPECIAL: begin
                    wd = w[15:11];
                    case (w[5:0])
                        core_pkg::FN_ADDU: res = a + b;
                        core_pkg::FN_SUBU: res = a - b;
                        core_pkg::FN_AND:  res = a & b;
                        core_pkg::FN_OR:   res = a | b;
                        core_pkg::FN_XOR:  res = a ^ b;
                        core_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        core_pkg::FN_SLL:  res = b << w[10:6];
                        default:           wr = 1'b0;
                    endcase
                end
                core_pkg::OP_ADDIU: res = a + se;
                core_pkg::OP_ORI:   res = a | {16'h0, w[15:0]};
                core_pkg::OP_LUI:   res = {w[15:0], 16'h0};
                core_pkg::OP_LW: begin
                    addr = a + se;
                    res  = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
                end
                core_pkg::OP_SW: begin
                    wr            = 1'b0;
                    addr          = a + se;
                    ref_mem[addr] = b;
                    add_expected(1'b1, inst_test[idx], pc, addr, b);
                end
                core_pkg::OP_BEQ, core_pkg::OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (w[31:26] == core_pkg::OP_BEQ)) begin
                        nxt = pc + 32'd4 + (se << 2);
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && wd != 5'd0) begin
                regs[wd] = res;
                add_expected(1'b0, inst_test[idx], pc, {27'h0, wd}, res);
            end
            pc  = npc;
            npc = nxt;
        end
    endtask

    task automatic count_error(logic [7:0] t);
        n_errors++;
        test_err[t]++;
    endtask

    task automatic report_test(int t);
        $display("test %s finished, %0d errors", test_name[t], test_err[t]);
        tests_done++;
    endtask

    task automatic retire(logic [7:0] t);
        remaining[t]--;
        if (remaining[t] == 0) begin
            report_test(t);
        end
    endtask

    // pick up the entry that the next rising edge compares against
    always @(negedge clk_i) begin
        if (!rst_i && !reset_reported && cyc == 5) begin
            reset_reported = 1'b1;
            report_test(0);
        end
        if (debug_wb_wen_o != 4'h0) begin
            wb_have = wb_q.size() > 0;
            if (wb_have) begin
                wb_exp = wb_q.pop_front();
            end
            n_checks++;
        end
        if (dbus_en_o && dbus_wen_o != 4'h0) begin
            st_have = st_q.size() > 0;
            if (st_have) begin
                st_exp = st_q.pop_front();
            end
            dmem[dbus_addr_o[9:2]] = dbus_wdata_o;
            n_checks++;
        end
    end

    // retire after the rising edge has checked the entry
    always @(posedge clk_i) begin
        if (!rst_i && debug_wb_wen_o != 4'h0 && wb_have) begin
            retire(wb_exp.test);
        end
        if (!rst_i && dbus_en_o && dbus_wen_o != 4'h0 && st_have) begin
            retire(st_exp.test);
        end
    end

    a_reset_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        cyc < 5 |-> debug_wb_wen_o == 4'h0 && !dbus_en_o)
        else begin
            $display("bus or trace activity at %0t, %0d cycles after reset", $time, cyc);
            count_error(0);
        end

    // pc holds one cycle while fetch starts up
    a_reset_fetch: assert property (@(posedge clk_i) disable iff (rst_i)
        cyc < 5 |-> ibus_en_o == (cyc != 0) &&
            ibus_addr_o == (ibus_en_o ? RESET_PC + 32'(4 * (cyc - 1)) : RESET_PC))
        else begin
            $display("[ERROR] %0t: fetch address %h at cycle %0d", $time, ibus_addr_o, cyc);
            count_error(0);
        end

    a_wb_trace: assert property (@(posedge clk_i) disable iff (rst_i)
        debug_wb_wen_o != 4'h0 |-> wb_have && debug_wb_wen_o == 4'hf &&
            debug_wb_pc_o == wb_exp.pc &&
            debug_wb_wraddr_o == wb_exp.key[4:0] && debug_wb_wrdata_o == wb_exp.value)
        else begin
            if (!wb_have) begin
                $display("unexpected register write to r%0d at %0t", debug_wb_wraddr_o, $time);
            end else begin
                $display("[ERROR] %0t: pc %h writes r%0d = %h, expected pc %h r%0d = %h",
                         $time, debug_wb_pc_o, debug_wb_wraddr_o, debug_wb_wrdata_o,
                         wb_exp.pc, wb_exp.key[4:0], wb_exp.value);
            end
            count_error(wb_exp.test);
        end

    a_store: assert property (@(posedge clk_i) disable iff (rst_i)
        dbus_wen_o != 4'h0 |-> st_have && dbus_en_o && dbus_wen_o == 4'hf &&
            dbus_addr_o == st_exp.key && dbus_wdata_o == st_exp.value)
        else begin
            if (!st_have) begin
                $display("unexpected store to %h at %0t", dbus_addr_o, $time);
            end else begin
                $display("[ERROR] %0t: store %h to %h, enables %b, expected %h to %h", $time,
                         dbus_wdata_o, dbus_addr_o, dbus_wen_o, st_exp.value, st_exp.key);
            end
            count_error(st_exp.test);
        end

    initial begin
        rst_i          = 1'b1;
        wb_have        = 1'b0;
        st_have        = 1'b0;
        reset_reported = 1'b0;
        test_name      = '{"reset", "forwarding", "load_use", "branch", "store"};
        void'($urandom(SEED));
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(32'(i * 4));
        end
        build_program();
        model_program();
        limit = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            limit += (n_inst[t] + 8) * 2;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i      = 1'b0;
        run_cycles = 0;
        while (tests_done < N_TESTS && run_cycles < limit) begin
            @(negedge clk_i);
            run_cycles++;
        end
        // a few more cycles to catch stray writes
        repeat (4) @(negedge clk_i);
        if (tests_done < N_TESTS) begin
            $display("timeout after %0d cycles, %0d of %0d tests finished",
                     run_cycles, tests_done, N_TESTS);
        end
        $display("tests %0d of %0d, checks %0d, errors %0d",
                 tests_done, N_TESTS, n_checks, n_errors);
        if (n_errors == 0 && tests_done == N_TESTS) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/core_top.sv ====
// core top level, connects the five pipeline stages to the instruction bus, data bus and trace port
`timescale 1ns/1ps

module core_top #(
    parameter core_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                clk_i,
    input  logic                rst_i,

    output logic                ibus_en_o,
    output core_pkg::word_t     ibus_addr_o,
    input  core_pkg::word_t     ibus_rdata_i,

    output logic                dbus_en_o,
    output logic [3:0]          dbus_wen_o,
    output core_pkg::word_t     dbus_addr_o,
    output core_pkg::word_t     dbus_wdata_o,
    input  core_pkg::word_t     dbus_rdata_i,

    output core_pkg::word_t     debug_wb_pc_o,
    output logic [3:0]          debug_wb_wen_o,
    output core_pkg::reg_addr_t debug_wb_wraddr_o,
    output core_pkg::word_t     debug_wb_wrdata_o
);

    core_pkg::if_id_t  if_id;
    core_pkg::id_ex_t  id_ex;
    core_pkg::ex_mem_t ex_mem;
    core_pkg::mem_wb_t mem_wb;
    core_pkg::fwd_t    ex_fwd;
    core_pkg::fwd_t    mem_fwd;
    core_pkg::word_t   branch_target;
    logic              branch_taken;
    logic              stall;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .ibus_rdata_i    (ibus_rdata_i),
        .ibus_en_o       (ibus_en_o),
        .ibus_addr_o     (ibus_addr_o),
        .if_id_o         (if_id)
    );

    decode_stage u_decode (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .if_id_i         (if_id),
        .ex_fwd_i        (ex_fwd),
        .mem_fwd_i       (mem_fwd),
        .wb_i            (mem_wb),
        .stall_o         (stall),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .id_ex_o         (id_ex)
    );

    execute_stage u_execute (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .ex_mem_o (ex_mem)
    );

    memory_stage u_memory (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .ex_mem_i     (ex_mem),
        .dbus_rdata_i (dbus_rdata_i),
        .dbus_en_o    (dbus_en_o),
        .dbus_wen_o   (dbus_wen_o),
        .dbus_addr_o  (dbus_addr_o),
        .dbus_wdata_o (dbus_wdata_o),
        .mem_fwd_o    (mem_fwd),
        .mem_wb_o     (mem_wb)
    );

    // write-back trace
    assign debug_wb_pc_o     = mem_wb.pc;
    assign debug_wb_wen_o    = {4{mem_wb.we}};
    assign debug_wb_wraddr_o = mem_wb.dest;
    assign debug_wb_wrdata_o = mem_wb.wdata;

endmodule

// ==== hw/memory_stage.sv ====
// data bus access and load data selection, registers the memory/write-back register
`timescale 1ns/1ps

module memory_stage (
    input  logic              clk_i,
    input  logic              rst_i,
    input  core_pkg::ex_mem_t ex_mem_i,
    input  core_pkg::word_t   dbus_rdata_i,
    output logic              dbus_en_o,
    output logic [3:0]        dbus_wen_o,
    output core_pkg::word_t   dbus_addr_o,
    output core_pkg::word_t   dbus_wdata_o,
    output core_pkg::fwd_t    mem_fwd_o,
    output core_pkg::mem_wb_t mem_wb_o
);

    core_pkg::word_t wdata;

    // full words only, so every byte lane is written
    assign dbus_en_o    = ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store);
    assign dbus_wen_o   = {4{ex_mem_i.valid && ex_mem_i.is_store}};
    assign dbus_addr_o  = ex_mem_i.result;
    assign dbus_wdata_o = ex_mem_i.sdata;

    assign wdata = ex_mem_i.is_load ? dbus_rdata_i : ex_mem_i.result;

    always_comb begin
        mem_fwd_o.we        = ex_mem_i.valid && ex_mem_i.we;
        mem_fwd_o.dest      = ex_mem_i.dest;
        mem_fwd_o.value     = wdata;
        mem_fwd_o.not_ready = 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_wb_o.valid <= 1'b0;
            mem_wb_o.we    <= 1'b0;
        end else begin
            mem_wb_o.valid <= ex_mem_i.valid;
            mem_wb_o.we    <= ex_mem_i.valid && ex_mem_i.we;
            mem_wb_o.dest  <= ex_mem_i.dest;
            mem_wb_o.wdata <= wdata;
            mem_wb_o.pc    <= ex_mem_i.pc;
        end
    end

    // base and offset from decode must land on a word boundary
    a_word_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        dbus_en_o |-> dbus_addr_o[1:0] == 2'b00);

endmodule

// ==== hw/execute_stage.sv ====
// ALU and effective address generation, registers the result into the execute/memory register
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk_i,
    input  logic              rst_i,
    input  core_pkg::id_ex_t  id_ex_i,
    output core_pkg::fwd_t    ex_fwd_o,
    output core_pkg::ex_mem_t ex_mem_o
);

    core_pkg::word_t alu_res;
    core_pkg::word_t a, b;

    assign a = id_ex_i.opr1;
    assign b = id_ex_i.opr2;

    // loads and stores come in as ALU_ADD of base and offset
    always_comb begin
        case (id_ex_i.alu_op)
            core_pkg::ALU_ADD: alu_res = a + b;
            core_pkg::ALU_SUB: alu_res = a - b;
            core_pkg::ALU_AND: alu_res = a & b;
            core_pkg::ALU_OR:  alu_res = a | b;
            core_pkg::ALU_XOR: alu_res = a ^ b;
            core_pkg::ALU_SLT: alu_res = {31'b0, $signed(a) < $signed(b)};
            core_pkg::ALU_SLL: alu_res = a << b[4:0];
            core_pkg::ALU_LUI: alu_res = b;
            default:           alu_res = '0;
        endcase
    end

    // load results are not known until the memory stage
    always_comb begin
        ex_fwd_o.we        = id_ex_i.valid && id_ex_i.we;
        ex_fwd_o.dest      = id_ex_i.dest;
        ex_fwd_o.value     = alu_res;
        ex_fwd_o.not_ready = id_ex_i.is_load;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_mem_o.valid <= 1'b0;
        end else begin
            ex_mem_o.valid    <= id_ex_i.valid;
            ex_mem_o.result   <= alu_res;
            ex_mem_o.sdata    <= id_ex_i.sdata;
            ex_mem_o.we       <= id_ex_i.we;
            ex_mem_o.dest     <= id_ex_i.dest;
            ex_mem_o.is_load  <= id_ex_i.is_load;
            ex_mem_o.is_store <= id_ex_i.is_store;
            ex_mem_o.pc       <= id_ex_i.pc;
        end
    end

endmodule

// ==== hw/decode_stage.sv ====
// instruction decode, operand forwarding, branch resolution and load-use stall
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk_i,
    input  logic              rst_i,
    input  core_pkg::if_id_t  if_id_i,
    input  core_pkg::fwd_t    ex_fwd_i,
    input  core_pkg::fwd_t    mem_fwd_i,
    input  core_pkg::mem_wb_t wb_i,
    output logic              stall_o,
    output logic              branch_taken_o,
    output core_pkg::word_t   branch_target_o,
    output core_pkg::id_ex_t  id_ex_o
);

    core_pkg::inst_u   inst;
    core_pkg::word_t   rf_rs, rf_rt;
    core_pkg::word_t   rs_val, rt_val;
    core_pkg::word_t   imm_sext;
    core_pkg::id_ex_t  id_ex_d;
    logic              use_rs, use_rt;
    logic              is_beq, is_bne;
    logic              load_hazard;

    // newest producer wins
    function automatic core_pkg::word_t fwd_value(core_pkg::reg_addr_t ra,
                                                  core_pkg::word_t rf_val,
                                                  core_pkg::fwd_t ex,
                                                  core_pkg::fwd_t mem);
        if (ex.we && ex.dest == ra) begin
            return ex.value;
        end
        if (mem.we && mem.dest == ra) begin
            return mem.value;
        end
        return rf_val;
    endfunction

    assign inst = if_id_i.inst;

    reg_file u_reg_file (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .ra1_i (inst.r.rs),
        .ra2_i (inst.r.rt),
        .rd1_o (rf_rs),
        .rd2_o (rf_rt),
        .we_i  (wb_i.valid && wb_i.we),
        .wa_i  (wb_i.dest),
        .wd_i  (wb_i.wdata)
    );

    assign rs_val   = fwd_value(inst.r.rs, rf_rs, ex_fwd_i, mem_fwd_i);
    assign rt_val   = fwd_value(inst.r.rt, rf_rt, ex_fwd_i, mem_fwd_i);
    assign imm_sext = {{16{inst.i.imm[15]}}, inst.i.imm};

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.alu_op   = core_pkg::ALU_NOP;
        id_ex_d.opr1     = rs_val;
        id_ex_d.opr2     = rt_val;
        id_ex_d.sdata    = rt_val;
        id_ex_d.dest     = inst.i.rt;
        id_ex_d.pc       = if_id_i.pc;
        use_rs           = 1'b1;
        use_rt           = 1'b0;
        is_beq           = 1'b0;
        is_bne           = 1'b0;
        case (inst.i.opcode)
            core_pkg::OP_SPECIAL: begin
                use_rt       = 1'b1;
                id_ex_d.we   = 1'b1;
                id_ex_d.dest = inst.r.rd;
                case (inst.r.funct)
                    core_pkg::FN_ADDU: id_ex_d.alu_op = core_pkg::ALU_ADD;
                    core_pkg::FN_SUBU: id_ex_d.alu_op = core_pkg::ALU_SUB;
                    core_pkg::FN_AND:  id_ex_d.alu_op = core_pkg::ALU_AND;
                    core_pkg::FN_OR:   id_ex_d.alu_op = core_pkg::ALU_OR;
                    core_pkg::FN_XOR:  id_ex_d.alu_op = core_pkg::ALU_XOR;
                    core_pkg::FN_SLT:  id_ex_d.alu_op = core_pkg::ALU_SLT;
                    core_pkg::FN_SLL: begin
                        use_rs         = 1'b0;
                        id_ex_d.alu_op = core_pkg::ALU_SLL;
                        id_ex_d.opr1   = rt_val;
                        id_ex_d.opr2   = {27'b0, inst.r.shamt};
                    end
                    default: id_ex_d.we = 1'b0;
                endcase
            end
            core_pkg::OP_ADDIU: begin
                id_ex_d.alu_op = core_pkg::ALU_ADD;
                id_ex_d.opr2   = imm_sext;
                id_ex_d.we     = 1'b1;
            end
            core_pkg::OP_ORI: begin
                id_ex_d.alu_op = core_pkg::ALU_OR;
                id_ex_d.opr2   = {16'b0, inst.i.imm};
                id_ex_d.we     = 1'b1;
            end
            core_pkg::OP_LUI: begin
                use_rs         = 1'b0;
                id_ex_d.alu_op = core_pkg::ALU_LUI;
                id_ex_d.opr2   = {inst.i.imm, 16'b0};
                id_ex_d.we     = 1'b1;
            end
            core_pkg::OP_LW: begin
                id_ex_d.alu_op  = core_pkg::ALU_ADD;
                id_ex_d.opr2    = imm_sext;
                id_ex_d.we      = 1'b1;
                id_ex_d.is_load = 1'b1;
            end
            core_pkg::OP_SW: begin
                use_rt           = 1'b1;
                id_ex_d.alu_op   = core_pkg::ALU_ADD;
                id_ex_d.opr2     = imm_sext;
                id_ex_d.is_store = 1'b1;
            end
            core_pkg::OP_BEQ: begin
                use_rt = 1'b1;
                is_beq = 1'b1;
            end
            core_pkg::OP_BNE: begin
                use_rt = 1'b1;
                is_bne = 1'b1;
            end
            default: ;
        endcase
        // r0 is never written
        if (id_ex_d.dest == '0) begin
            id_ex_d.we = 1'b0;
        end
        id_ex_d.valid = if_id_i.valid && !stall_o;
    end

    // load in execute feeding a source used here
    assign load_hazard = ex_fwd_i.we && ex_fwd_i.not_ready &&
                         ((use_rs && inst.r.rs == ex_fwd_i.dest) ||
                          (use_rt && inst.r.rt == ex_fwd_i.dest));
    assign stall_o     = if_id_i.valid && load_hazard;

    assign branch_taken_o  = if_id_i.valid && !stall_o &&
                             ((is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val));
    assign branch_target_o = if_id_i.pc + 32'd4 + {imm_sext[29:0], 2'b00};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            id_ex_o.valid <= 1'b0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

    // the bubble behind a stall is never a load
    a_single_stall: assert property (@(posedge clk_i) disable iff (rst_i) stall_o |=> !stall_o);

endmodule

// ==== hw/reg_file.sv ====
// two-read one-write register file, a read of the word being written returns the new value
`timescale 1ns/1ps

module reg_file (
    input  logic                clk_i,
    input  logic                rst_i,
    input  core_pkg::reg_addr_t ra1_i,
    input  core_pkg::reg_addr_t ra2_i,
    output core_pkg::word_t     rd1_o,
    output core_pkg::word_t     rd2_o,
    input  logic                we_i,
    input  core_pkg::reg_addr_t wa_i,
    input  core_pkg::word_t     wd_i
);

    core_pkg::word_t regs [2**core_pkg::REG_AW];

    function automatic core_pkg::word_t read_port(core_pkg::reg_addr_t ra);
        if (ra == '0) begin
            return '0;
        end
        if (we_i && wa_i == ra) begin
            return wd_i;
        end
        return regs[ra];
    endfunction

    always_comb begin
        rd1_o = read_port(ra1_i);
        rd2_o = read_port(ra2_i);
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            regs[wa_i] <= wd_i;
        end
    end

    // decode drops writes to r0 before they reach write-back
    a_no_r0_write: assert property (@(posedge clk_i) disable iff (rst_i) we_i |-> wa_i != '0);

endmodule

// ==== hw/fetch_stage.sv ====
// program counter and instruction fetch, registers the fetched word into the fetch/decode register
`timescale 1ns/1ps

module fetch_stage #(
    parameter core_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             stall_i,
    input  logic             branch_taken_i,
    input  core_pkg::word_t  branch_target_i,
    input  core_pkg::word_t  ibus_rdata_i,
    output logic             ibus_en_o,
    output core_pkg::word_t  ibus_addr_o,
    output core_pkg::if_id_t if_id_o
);

    logic            run_q;
    core_pkg::word_t pc_q;
    core_pkg::word_t pc_next;

    assign ibus_en_o   = run_q;
    assign ibus_addr_o = pc_q;

    // target lands once the delay slot is being fetched
    assign pc_next = branch_taken_i ? branch_target_i : pc_q + 32'd4;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run_q         <= 1'b0;
            pc_q          <= RESET_PC;
            if_id_o.valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (run_q && !stall_i) begin
                pc_q          <= pc_next;
                if_id_o.pc    <= pc_q;
                if_id_o.inst  <= ibus_rdata_i;
                if_id_o.valid <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/core_pkg.sv ====
// shared widths, opcodes, instruction views and pipeline register types for the integer core
package core_pkg;

    parameter int XLEN   = 32;
    parameter int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } inst_i_t;

    // one word, read as R-format or I-format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef struct packed {
        word_t pc;
        inst_u inst;
        logic  valid;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        word_t     opr1;
        word_t     opr2;
        word_t     sdata;
        logic      we;
        reg_addr_t dest;
        logic      is_load;
        logic      is_store;
        word_t     pc;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     result;
        word_t     sdata;
        logic      we;
        reg_addr_t dest;
        logic      is_load;
        logic      is_store;
        word_t     pc;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t dest;
        word_t     wdata;
        word_t     pc;
    } mem_wb_t;

    // not_ready marks a load whose data is still on the way
    typedef struct packed {
        logic      we;
        reg_addr_t dest;
        word_t     value;
        logic      not_ready;
    } fwd_t;

endpackage
